// File: hdl/axi_defines.svh
`ifndef AXI_DEFINES_SVH
`define AXI_DEFINES_SVH

// AXI4 port widths
`define AXI_ID_WIDTH 1
`define AXI_DATA_WIDTH 32
`define AXI_ADDR_WIDTH 13
`define AXI_STRB_WIDTH 4

// word RAM geometry, 8 KB
`define MEM_WORDS 2048
`define MEM_ADDR_WIDTH 11

`endif

// File: hdl/axi_pkg.sv
package axi_pkg;

	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10,
		BURST_RSVD  = 2'b11
	} burst_t;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_t;

	// only fixed and incr are carried out
	function automatic resp_t burst_resp(burst_t kind);
		if (kind == BURST_FIXED || kind == BURST_INCR) begin
			return RESP_OKAY;
		end
		return RESP_SLVERR;
	endfunction

endpackage

// File: hdl/mem_pkg.sv
`include "axi_defines.svh"

package mem_pkg;

	typedef logic [`MEM_ADDR_WIDTH-1:0] word_addr_t;

	// whole word for reads, byte lanes for strobed writes
	typedef union packed {
		logic [`AXI_DATA_WIDTH-1:0] word;
		logic [`AXI_STRB_WIDTH-1:0][7:0] lanes;
	} mem_word_u;

endpackage

// File: hdl/mem_port_if.sv
`include "axi_defines.svh"

interface mem_port_if;

	logic wr_en;
	mem_pkg::word_addr_t wr_addr;
	mem_pkg::mem_word_u wr_data;
	logic [`AXI_STRB_WIDTH-1:0] wr_strb;

	logic rd_en;
	mem_pkg::word_addr_t rd_addr;
	mem_pkg::mem_word_u rd_data; // valid one cycle after rd_en

	modport wr_src (
		output wr_en,
		output wr_addr,
		output wr_data,
		output wr_strb
	);

	modport rd_src (
		output rd_en,
		output rd_addr,
		input rd_data
	);

	modport ram (
		input wr_en,
		input wr_addr,
		input wr_data,
		input wr_strb,
		input rd_en,
		input rd_addr,
		output rd_data
	);

endinterface

// File: hdl/axi_wr_channel.sv
`include "axi_defines.svh"

module axi_wr_channel (
	input logic s00_axi_aclk,
	input logic arst_n,
	input logic [`AXI_ID_WIDTH-1:0] awid,
	input logic [`AXI_ADDR_WIDTH-1:0] awaddr,
	input logic [7:0] awlen,
	input logic [1:0] awburst,
	input logic awvalid,
	output logic awready,
	input logic [`AXI_DATA_WIDTH-1:0] wdata,
	input logic [`AXI_STRB_WIDTH-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [`AXI_ID_WIDTH-1:0] bid,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	mem_port_if.wr_src mem
);

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_DATA,
		WR_RESP
	} wr_state_t;

	wr_state_t state;
	axi_pkg::burst_t burst;
	axi_pkg::resp_t resp;
	logic [7:0] len;
	logic [7:0] beat_cnt;
	mem_pkg::word_addr_t addr;
	logic aw_hs;
	logic w_hs;
	logic b_hs;

	assign aw_hs = awvalid && awready;
	assign w_hs = wvalid && wready;
	assign b_hs = bvalid && bready;

	// write goes out on the handshake itself
	assign mem.wr_en = w_hs && (resp == axi_pkg::RESP_OKAY);
	assign mem.wr_addr = addr;
	assign mem.wr_data = mem_pkg::mem_word_u'(wdata);
	assign mem.wr_strb = wstrb;

	assign bresp = resp;

	always_ff @(posedge s00_axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= WR_IDLE;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			beat_cnt <= '0;
		end else begin
			case (state)
				WR_IDLE: begin
					awready <= 1'b1;
					if (aw_hs) begin
						awready <= 1'b0;
						wready <= 1'b1;
						beat_cnt <= '0;
						state <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (w_hs) begin
						if (beat_cnt == len) begin // end by count, wlast ignored
							wready <= 1'b0;
							bvalid <= 1'b1;
							state <= WR_RESP;
						end else begin
							beat_cnt <= beat_cnt + 8'd1;
						end
					end
				end
				WR_RESP: begin
					if (b_hs) begin
						bvalid <= 1'b0;
						awready <= 1'b1;
						state <= WR_IDLE;
					end
				end
				default: begin
					state <= WR_IDLE;
				end
			endcase
		end
	end

	// burst context
	always_ff @(posedge s00_axi_aclk) begin
		if (aw_hs) begin
			bid <= awid;
			len <= awlen;
			burst <= axi_pkg::burst_t'(awburst);
			resp <= axi_pkg::burst_resp(axi_pkg::burst_t'(awburst));
			addr <= awaddr[`AXI_ADDR_WIDTH-1:2];
		end else if (w_hs && burst == axi_pkg::BURST_INCR) begin
			addr <= addr + 1'b1; // wraps in the word index
		end
	end

endmodule

// File: hdl/axi_rd_channel.sv
`include "axi_defines.svh"

module axi_rd_channel (
	input logic s00_axi_aclk,
	input logic arst_n,
	input logic [`AXI_ID_WIDTH-1:0] arid,
	input logic [`AXI_ADDR_WIDTH-1:0] araddr,
	input logic [7:0] arlen,
	input logic [1:0] arburst,
	input logic arvalid,
	output logic arready,
	output logic [`AXI_ID_WIDTH-1:0] rid,
	output logic [`AXI_DATA_WIDTH-1:0] rdata,
	output logic [1:0] rresp,
	output logic rlast,
	output logic rvalid,
	input logic rready,
	mem_port_if.rd_src mem
);

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_FETCH,
		RD_PRESENT,
		RD_HOLD
	} rd_state_t;

	rd_state_t state;
	axi_pkg::burst_t burst;
	axi_pkg::resp_t resp;
	logic [7:0] len;
	logic [7:0] beat_cnt;
	mem_pkg::word_addr_t addr;
	logic ar_hs;
	logic r_hs;

	assign ar_hs = arvalid && arready;
	assign r_hs = rvalid && rready;

	assign mem.rd_en = (state == RD_FETCH);
	assign mem.rd_addr = addr;

	// ram output stays put until the next rd_en
	assign rvalid = (state == RD_PRESENT) || (state == RD_HOLD);
	assign rdata = (resp == axi_pkg::RESP_OKAY) ? mem.rd_data.word : '0;
	assign rresp = resp;
	assign rlast = rvalid && (beat_cnt == len);

	always_ff @(posedge s00_axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= RD_IDLE;
			arready <= 1'b0;
			beat_cnt <= '0;
		end else begin
			case (state)
				RD_IDLE: begin
					arready <= 1'b1;
					if (ar_hs) begin
						arready <= 1'b0;
						beat_cnt <= '0;
						state <= RD_FETCH;
					end
				end
				RD_FETCH: begin
					state <= RD_PRESENT;
				end
				RD_PRESENT, RD_HOLD: begin
					if (r_hs) begin
						if (beat_cnt == len) begin
							arready <= 1'b1;
							state <= RD_IDLE;
						end else begin
							beat_cnt <= beat_cnt + 8'd1;
							state <= RD_FETCH; // one idle cycle per beat
						end
					end else begin
						state <= RD_HOLD;
					end
				end
				default: begin
					state <= RD_IDLE;
				end
			endcase
		end
	end

	// burst context
	always_ff @(posedge s00_axi_aclk) begin
		if (ar_hs) begin
			rid <= arid;
			len <= arlen;
			burst <= axi_pkg::burst_t'(arburst);
			resp <= axi_pkg::burst_resp(axi_pkg::burst_t'(arburst));
			addr <= araddr[`AXI_ADDR_WIDTH-1:2];
		end else if (r_hs && burst == axi_pkg::BURST_INCR) begin
			addr <= addr + 1'b1;
		end
	end

endmodule

// File: hdl/word_ram.sv
`include "axi_defines.svh"

module word_ram (
	input logic s00_axi_aclk,
	mem_port_if.ram mem
);

	mem_pkg::mem_word_u ram_q [`MEM_WORDS];

	// strobed lanes only
	always_ff @(posedge s00_axi_aclk) begin
		if (mem.wr_en) begin
			for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
				if (mem.wr_strb[i]) begin
					ram_q[mem.wr_addr].lanes[i] <= mem.wr_data.lanes[i];
				end
			end
		end
	end

	always_ff @(posedge s00_axi_aclk) begin
		if (mem.rd_en) begin
			mem.rd_data <= ram_q[mem.rd_addr];
		end
	end

endmodule

// File: hdl/axi4_mm_slave.sv
`include "axi_defines.svh"

module axi4_mm_slave (
	input logic s00_axi_aclk,
	input logic arst_n,
	input logic [`AXI_ID_WIDTH-1:0] s00_axi_awid,
	input logic [`AXI_ADDR_WIDTH-1:0] s00_axi_awaddr,
	input logic [7:0] s00_axi_awlen,
	input logic [2:0] s00_axi_awsize,
	input logic [1:0] s00_axi_awburst,
	input logic s00_axi_awlock,
	input logic [3:0] s00_axi_awcache,
	input logic [2:0] s00_axi_awprot,
	input logic [3:0] s00_axi_awqos,
	input logic [3:0] s00_axi_awregion,
	input logic s00_axi_awuser,
	input logic s00_axi_awvalid,
	output logic s00_axi_awready,
	input logic [`AXI_DATA_WIDTH-1:0] s00_axi_wdata,
	input logic [`AXI_STRB_WIDTH-1:0] s00_axi_wstrb,
	input logic s00_axi_wlast,
	input logic s00_axi_wuser,
	input logic s00_axi_wvalid,
	output logic s00_axi_wready,
	output logic [`AXI_ID_WIDTH-1:0] s00_axi_bid,
	output logic [1:0] s00_axi_bresp,
	output logic s00_axi_buser,
	output logic s00_axi_bvalid,
	input logic s00_axi_bready,
	input logic [`AXI_ID_WIDTH-1:0] s00_axi_arid,
	input logic [`AXI_ADDR_WIDTH-1:0] s00_axi_araddr,
	input logic [7:0] s00_axi_arlen,
	input logic [2:0] s00_axi_arsize,
	input logic [1:0] s00_axi_arburst,
	input logic s00_axi_arlock,
	input logic [3:0] s00_axi_arcache,
	input logic [2:0] s00_axi_arprot,
	input logic [3:0] s00_axi_arqos,
	input logic [3:0] s00_axi_arregion,
	input logic s00_axi_aruser,
	input logic s00_axi_arvalid,
	output logic s00_axi_arready,
	output logic [`AXI_ID_WIDTH-1:0] s00_axi_rid,
	output logic [`AXI_DATA_WIDTH-1:0] s00_axi_rdata,
	output logic [1:0] s00_axi_rresp,
	output logic s00_axi_rlast,
	output logic s00_axi_ruser,
	output logic s00_axi_rvalid,
	input logic s00_axi_rready
);

	// size, lock, cache, prot, qos, region, user and wlast are not used
	mem_port_if mem_bus ();

	assign s00_axi_buser = 1'b0;
	assign s00_axi_ruser = 1'b0;

	axi_wr_channel u_wr (
		.s00_axi_aclk(s00_axi_aclk),
		.arst_n(arst_n),
		.awid(s00_axi_awid),
		.awaddr(s00_axi_awaddr),
		.awlen(s00_axi_awlen),
		.awburst(s00_axi_awburst),
		.awvalid(s00_axi_awvalid),
		.awready(s00_axi_awready),
		.wdata(s00_axi_wdata),
		.wstrb(s00_axi_wstrb),
		.wvalid(s00_axi_wvalid),
		.wready(s00_axi_wready),
		.bid(s00_axi_bid),
		.bresp(s00_axi_bresp),
		.bvalid(s00_axi_bvalid),
		.bready(s00_axi_bready),
		.mem(mem_bus.wr_src)
	);

	axi_rd_channel u_rd (
		.s00_axi_aclk(s00_axi_aclk),
		.arst_n(arst_n),
		.arid(s00_axi_arid),
		.araddr(s00_axi_araddr),
		.arlen(s00_axi_arlen),
		.arburst(s00_axi_arburst),
		.arvalid(s00_axi_arvalid),
		.arready(s00_axi_arready),
		.rid(s00_axi_rid),
		.rdata(s00_axi_rdata),
		.rresp(s00_axi_rresp),
		.rlast(s00_axi_rlast),
		.rvalid(s00_axi_rvalid),
		.rready(s00_axi_rready),
		.mem(mem_bus.rd_src)
	);

	word_ram u_ram (
		.s00_axi_aclk(s00_axi_aclk),
		.mem(mem_bus.ram)
	);

endmodule

// File: verif/tb_checker.sv
`include "axi_defines.svh"

module tb_checker (
	input logic s00_axi_aclk,
	input logic arst_n,
	input logic [`AXI_ID_WIDTH-1:0] s00_axi_awid, s00_axi_arid, s00_axi_bid, s00_axi_rid,
	input logic [`AXI_ADDR_WIDTH-1:0] s00_axi_awaddr, s00_axi_araddr,
	input logic [7:0] s00_axi_awlen, s00_axi_arlen,
	input logic [1:0] s00_axi_awburst, s00_axi_arburst, s00_axi_bresp, s00_axi_rresp,
	input logic s00_axi_awvalid, s00_axi_awready, s00_axi_arvalid, s00_axi_arready,
	input logic [`AXI_DATA_WIDTH-1:0] s00_axi_wdata, s00_axi_rdata,
	input logic [`AXI_STRB_WIDTH-1:0] s00_axi_wstrb,
	input logic s00_axi_wvalid, s00_axi_wready,
	input logic s00_axi_buser, s00_axi_bvalid, s00_axi_bready,
	input logic s00_axi_rlast, s00_axi_ruser, s00_axi_rvalid, s00_axi_rready,
	output int data_errs,
	output int proto_errs
);

	logic [31:0] model [`MEM_WORDS];
	logic wr_open, b_due, b_hold, wr_id, rd_open, fetch_due, present_due, r_hold, rd_id;
	logic [7:0] wr_len, wr_beat, rd_len, rd_beat;
	logic [1:0] wr_burst, rd_burst, held_resp;
	logic [10:0] wr_addr, rd_addr;
	logic [31:0] exp_word, held_data;
	logic held_last;
	logic rst_seen;
	int rel_cnt;

	function automatic logic burst_ok(logic [1:0] kind);
		return kind == axi_pkg::BURST_FIXED || kind == axi_pkg::BURST_INCR;
	endfunction

	task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			data_errs++;
			$display("ERR %s exp=%h act=%h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic protocol_error(string msg);
		proto_errs++;
		$display("protocol error at %0t: %s", $time, msg);
	endtask

	initial begin
		data_errs = 0;
		proto_errs = 0;
		rst_seen = 1'b0;
	end

	always @(posedge s00_axi_aclk) begin
		if (!arst_n) begin
			rel_cnt = 0;
			if (rst_seen) begin // outputs may still be x before the first reset edge
				check_value("s00_axi_awready", 0, s00_axi_awready);
				check_value("s00_axi_wready", 0, s00_axi_wready);
				check_value("s00_axi_bvalid", 0, s00_axi_bvalid);
				check_value("s00_axi_arready", 0, s00_axi_arready);
				check_value("s00_axi_rvalid", 0, s00_axi_rvalid);
			end
			rst_seen = 1'b1;
			{wr_open, b_due, b_hold, rd_open, fetch_due, present_due, r_hold} = '0;
		end else begin
			if (rel_cnt < 3) rel_cnt++;
			if (rel_cnt == 2) begin // readies up one cycle after release
				check_value("s00_axi_awready", 1, s00_axi_awready);
				check_value("s00_axi_arready", 1, s00_axi_arready);
			end
			if (present_due) begin
				present_due = 1'b0;
				if (!s00_axi_rvalid) protocol_error("rvalid not up two cycles after fetch start");
			end
			if (fetch_due) begin
				if (s00_axi_rvalid) protocol_error("rvalid high while the next word is read");
				exp_word = burst_ok(rd_burst) ? model[rd_addr] : 32'h0; // before this edge's write
				fetch_due = 1'b0;
				present_due = 1'b1;
			end
			if (r_hold && (!s00_axi_rvalid || s00_axi_rdata !== held_data
					|| s00_axi_rresp !== held_resp || s00_axi_rlast !== held_last))
				protocol_error("R channel changed before rready");
			r_hold = s00_axi_rvalid && !s00_axi_rready;
			held_data = s00_axi_rdata;
			held_resp = s00_axi_rresp;
			held_last = s00_axi_rlast;
			if (s00_axi_rvalid && !rd_open) protocol_error("rvalid with no open read burst");
			if (s00_axi_rvalid && s00_axi_rready && rd_open) begin
				check_value("s00_axi_rdata", exp_word, s00_axi_rdata);
				check_value("s00_axi_rresp", burst_ok(rd_burst) ? 0 : 2, s00_axi_rresp);
				check_value("s00_axi_rid", rd_id, s00_axi_rid);
				check_value("s00_axi_rlast", rd_beat == rd_len, s00_axi_rlast);
				check_value("s00_axi_ruser", 0, s00_axi_ruser);
				if (rd_beat == rd_len) begin
					rd_open = 1'b0;
				end else begin
					rd_beat++;
					fetch_due = 1'b1;
					if (rd_burst == axi_pkg::BURST_INCR) rd_addr++;
				end
			end
			if (s00_axi_wvalid && s00_axi_wready) begin
				if (!wr_open || b_due) begin
					protocol_error("W beat accepted outside a write burst");
				end else begin
					for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
						if (burst_ok(wr_burst) && s00_axi_wstrb[i])
							model[wr_addr][i*8 +: 8] = s00_axi_wdata[i*8 +: 8];
					end
					if (wr_beat == wr_len) b_due = 1'b1;
					else wr_beat++;
					if (wr_burst == axi_pkg::BURST_INCR) wr_addr++;
				end
			end
			if (b_hold && !s00_axi_bvalid) protocol_error("bvalid dropped before bready");
			b_hold = s00_axi_bvalid && !s00_axi_bready;
			if (s00_axi_bvalid && !b_due) protocol_error("bvalid without a completed write burst");
			if (s00_axi_bvalid && s00_axi_bready && b_due) begin
				check_value("s00_axi_bid", wr_id, s00_axi_bid);
				check_value("s00_axi_bresp", burst_ok(wr_burst) ? 0 : 2, s00_axi_bresp);
				check_value("s00_axi_buser", 0, s00_axi_buser);
				b_due = 1'b0;
				wr_open = 1'b0;
			end
			if (s00_axi_arvalid && s00_axi_arready) begin
				rd_open = 1'b1;
				rd_id = s00_axi_arid;
				rd_len = s00_axi_arlen;
				rd_beat = 8'd0;
				rd_burst = s00_axi_arburst;
				rd_addr = s00_axi_araddr[`AXI_ADDR_WIDTH-1:2];
				fetch_due = 1'b1;
			end
			if (s00_axi_awvalid && s00_axi_awready) begin
				wr_open = 1'b1;
				wr_id = s00_axi_awid;
				wr_len = s00_axi_awlen;
				wr_beat = 8'd0;
				wr_burst = s00_axi_awburst;
				wr_addr = s00_axi_awaddr[`AXI_ADDR_WIDTH-1:2];
			end
		end
	end

endmodule

// File: verif/tb_top.sv
`include "axi_defines.svh"

module tb_top;

	localparam int NUM_TXN = 200;
	localparam int PREFILL_BURSTS = 17; // 272 words, covers incr runs past word 255
	localparam int WATCHDOG_CYCLES = (NUM_TXN + PREFILL_BURSTS) * 16 * 20;

	logic s00_axi_aclk;
	logic arst_n;
	logic [`AXI_ID_WIDTH-1:0] s00_axi_awid, s00_axi_arid, s00_axi_bid, s00_axi_rid;
	logic [`AXI_ADDR_WIDTH-1:0] s00_axi_awaddr, s00_axi_araddr;
	logic [7:0] s00_axi_awlen, s00_axi_arlen;
	logic [2:0] s00_axi_awsize, s00_axi_arsize, s00_axi_awprot, s00_axi_arprot;
	logic [1:0] s00_axi_awburst, s00_axi_arburst, s00_axi_bresp, s00_axi_rresp;
	logic [3:0] s00_axi_awcache, s00_axi_arcache, s00_axi_awqos, s00_axi_arqos;
	logic [3:0] s00_axi_awregion, s00_axi_arregion;
	logic s00_axi_awlock, s00_axi_arlock, s00_axi_awuser, s00_axi_aruser;
	logic s00_axi_awvalid, s00_axi_awready, s00_axi_arvalid, s00_axi_arready;
	logic [`AXI_DATA_WIDTH-1:0] s00_axi_wdata, s00_axi_rdata;
	logic [`AXI_STRB_WIDTH-1:0] s00_axi_wstrb;
	logic s00_axi_wlast, s00_axi_wuser, s00_axi_wvalid, s00_axi_wready;
	logic s00_axi_buser, s00_axi_bvalid, s00_axi_bready;
	logic s00_axi_rlast, s00_axi_ruser, s00_axi_rvalid, s00_axi_rready;
	int data_errs;
	int proto_errs;
	int n_wr;

	axi4_mm_slave uut (.*);
	tb_checker chk (.*);

	initial begin
		s00_axi_aclk = 1'b0;
		forever #4 s00_axi_aclk = ~s00_axi_aclk;
	end

	// mostly incr, some fixed, rare wrap
	function automatic logic [1:0] pick_burst();
		int r;
		r = $urandom % 16;
		if (r == 0) return axi_pkg::BURST_WRAP;
		if (r < 4) return axi_pkg::BURST_FIXED;
		return axi_pkg::BURST_INCR;
	endfunction

	task automatic write_burst(input logic id, input logic [12:0] addr, input logic [7:0] len,
			input logic [1:0] burst, input bit full_strb);
		int gap;
		logic hs;
		s00_axi_awid <= id;
		s00_axi_awaddr <= addr;
		s00_axi_awlen <= len;
		s00_axi_awburst <= burst;
		s00_axi_awvalid <= 1'b1;
		do @(posedge s00_axi_aclk); while (!s00_axi_awready);
		s00_axi_awvalid <= 1'b0;
		for (int b = 0; b <= len; b++) begin
			gap = full_strb ? 0 : $urandom % 3;
			if (gap > 0) begin
				s00_axi_wvalid <= 1'b0; // hold back W
				repeat (gap) @(posedge s00_axi_aclk);
			end
			s00_axi_wdata <= $urandom;
			s00_axi_wstrb <= full_strb ? 4'hf : 4'($urandom);
			s00_axi_wlast <= (b == len);
			s00_axi_wvalid <= 1'b1;
			do @(posedge s00_axi_aclk); while (!s00_axi_wready);
		end
		s00_axi_wvalid <= 1'b0;
		s00_axi_wlast <= 1'b0;
		s00_axi_bready <= 1'($urandom % 2);
		do begin
			@(posedge s00_axi_aclk);
			hs = s00_axi_bvalid && s00_axi_bready;
			if (!hs) s00_axi_bready <= 1'($urandom % 2);
		end while (!hs);
		s00_axi_bready <= 1'b0;
	endtask

	task automatic read_burst(input logic id, input logic [12:0] addr, input logic [7:0] len,
			input logic [1:0] burst);
		logic done;
		s00_axi_arid <= id;
		s00_axi_araddr <= addr;
		s00_axi_arlen <= len;
		s00_axi_arburst <= burst;
		s00_axi_arvalid <= 1'b1;
		do @(posedge s00_axi_aclk); while (!s00_axi_arready);
		s00_axi_arvalid <= 1'b0;
		s00_axi_rready <= 1'($urandom % 2);
		do begin
			@(posedge s00_axi_aclk);
			done = s00_axi_rvalid && s00_axi_rready && s00_axi_rlast;
			s00_axi_rready <= done ? 1'b0 : 1'($urandom % 2);
		end while (!done);
	endtask

	initial begin
		void'($urandom(8711));
		arst_n = 1'b0;
		{s00_axi_awid, s00_axi_awaddr, s00_axi_awlen, s00_axi_awburst, s00_axi_awvalid} = '0;
		{s00_axi_arid, s00_axi_araddr, s00_axi_arlen, s00_axi_arburst, s00_axi_arvalid} = '0;
		{s00_axi_awlock, s00_axi_awcache, s00_axi_awprot, s00_axi_awqos} = '0;
		{s00_axi_arlock, s00_axi_arcache, s00_axi_arprot, s00_axi_arqos} = '0;
		{s00_axi_awregion, s00_axi_arregion, s00_axi_awuser, s00_axi_aruser} = '0;
		s00_axi_awsize = 3'd2;
		s00_axi_arsize = 3'd2;
		{s00_axi_wdata, s00_axi_wstrb, s00_axi_wlast, s00_axi_wuser, s00_axi_wvalid} = '0;
		s00_axi_bready = 1'b0;
		s00_axi_rready = 1'b0;
		repeat (16) @(posedge s00_axi_aclk);
		arst_n <= 1'b1;
		repeat (3) @(posedge s00_axi_aclk);
		for (int i = 0; i < PREFILL_BURSTS; i++) begin
			write_burst(1'b0, 13'(i * 64), 8'd15, axi_pkg::BURST_INCR, 1'b1);
		end
		n_wr = 0;
		for (int i = 0; i < NUM_TXN; i++) begin
			if ($urandom % 2) n_wr++;
		end
		fork
			for (int i = 0; i < n_wr; i++) begin
				repeat ($urandom % 4) @(posedge s00_axi_aclk);
				write_burst(1'($urandom), 13'($urandom % 1024), 8'($urandom % 16),
					pick_burst(), 1'b0);
			end
			for (int i = 0; i < NUM_TXN - n_wr; i++) begin
				repeat ($urandom % 4) @(posedge s00_axi_aclk);
				read_burst(1'($urandom), 13'($urandom % 1024), 8'($urandom % 16), pick_burst());
			end
		join
		repeat (4) @(posedge s00_axi_aclk);
		$display("errors: data %0d protocol %0d", data_errs, proto_errs);
		if (data_errs + proto_errs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge s00_axi_aclk);
		$display("timeout, transactions did not finish; errors: data %0d protocol %0d",
			data_errs, proto_errs);
		$display("sim failed");
		$finish;
	end

endmodule

// File: all.f
+incdir+hdl
hdl/axi_pkg.sv
hdl/mem_pkg.sv
hdl/mem_port_if.sv
hdl/axi_wr_channel.sv
hdl/axi_rd_channel.sv
hdl/word_ram.sv
hdl/axi4_mm_slave.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: Bender.yml
package:
  name: axi4_mm_slave

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/axi_pkg.sv
      - hdl/mem_pkg.sv
      - hdl/mem_port_if.sv
      - hdl/axi_wr_channel.sv
      - hdl/axi_rd_channel.sv
      - hdl/word_ram.sv
      - hdl/axi4_mm_slave.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/tb_checker.sv
      - verif/tb_top.sv
